// File: audio_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb2p_cfg.svh"

module audio_select (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  gb2p_pkg::audio_mode_t mode,
	input  gb2p_pkg::stereo_t     core1,
	input  gb2p_pkg::stereo_t     core2,
	output gb2p_pkg::stereo_t     mix
);

	logic signed [`GB2P_AUDIO_W-1:0] l1_half;
	logic signed [`GB2P_AUDIO_W-1:0] r1_half;
	logic signed [`GB2P_AUDIO_W-1:0] l2_half;
	logic signed [`GB2P_AUDIO_W-1:0] r2_half;
	gb2p_pkg::stereo_t               mix_next;

	// Halving first keeps every sum inside 16 bits
	assign l1_half = core1.left >>> 1;
	assign r1_half = core1.right >>> 1;
	assign l2_half = core2.left >>> 1;
	assign r2_half = core2.right >>> 1;

	always_comb begin
		case (mode)
			gb2p_pkg::CORE2: mix_next = core2;
			gb2p_pkg::MIXED: begin
				mix_next.left  = l1_half + l2_half;
				mix_next.right = r1_half + r2_half;
			end
			// Console 1 on the left, console 2 on the right
			gb2p_pkg::SPLIT: begin
				mix_next.left  = l1_half + r1_half;
				mix_next.right = l2_half + r2_half;
			end
			default: mix_next = core1;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			mix <= '0;
		else
			mix <= mix_next;
	end

endmodule

`default_nettype wire

// File: backup_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb2p_cfg.svh"

module backup_sequencer (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  gb2p_pkg::save_opts_t opts,
	input  wire                  downloading,
	input  wire                  cart_start,
	input  wire                  cart_end,
	input  wire                  osd_open,
	input  wire                  img_mounted,
	input  wire                  img_readonly,
	input  wire [63:0]           img_size,
	input  wire [1:0]            cram_wr,
	input  wire [1:0]            has_save,
	input  gb2p_pkg::sd_rsp_t    sd_rsp,
	output gb2p_pkg::sd_req_t    sd_req,
	output gb2p_pkg::bk_wr_t     bk,
	output logic                 bk_loading,
	output logic                 bk_busy,
	output logic                 sav_pending
);

	logic        bk_ena;
	logic        new_load;
	logic        sav_supported;
	logic        bk_load;
	logic        bk_save;
	logic        old_load;
	logic        old_save;
	logic        old_ack;
	logic        last_sector;
	logic [31:0] lba;
	logic        rd;
	logic        wr;

	assign sav_supported = (|has_save) && bk_ena;
	assign bk_load = opts.load_req | new_load;
	assign bk_save = opts.save_req | (sav_pending & osd_open & opts.autosave);

	// Dupe mode only holds half the image
	assign last_sector = (lba[8:0] == `GB2P_LAST_SECTOR) ||
		(opts.dupe_save && lba[8:0] == `GB2P_LAST_SECTOR_DUPE);

	////////////////////////////////////////////////////////////
	// Save enable and pending flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena      <= 1'b0;
			new_load    <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			if (cart_start)
				bk_ena <= 1'b0;
			// Host mounts the save file before the cart download ends
			if (downloading && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (cart_end && sav_supported)
				new_load <= 1'b1;
			else if (bk_busy)
				new_load <= 1'b0;

			if ((|cram_wr) && !osd_open && sav_supported)
				sav_pending <= 1'b1;
			else if (bk_busy)
				sav_pending <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Sector stepping
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			lba        <= '0;
			rd         <= 1'b0;
			wr         <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_ack  <= sd_rsp.ack;

			// Host took the request
			if (!old_ack && sd_rsp.ack) begin
				rd <= 1'b0;
				wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (bk_ena && ((!old_load && bk_load) || (!old_save && bk_save))) begin
					bk_busy    <= 1'b1;
					bk_loading <= bk_load;
					lba        <= '0;
					rd         <= bk_load;
					wr         <= ~bk_load;
				end
				// Auto load of a fresh cart
				if (cart_end && (|img_size) && bk_ena) begin
					bk_busy    <= 1'b1;
					bk_loading <= 1'b1;
					lba        <= '0;
					rd         <= 1'b1;
					wr         <= 1'b0;
				end
			end else if (old_ack && !sd_rsp.ack) begin
				if (last_sector) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					lba <= lba + 32'd1;
					rd  <= bk_loading;
					wr  <= ~bk_loading;
				end
			end
		end
	end

	assign sd_req.lba = lba;
	assign sd_req.rd  = rd;
	assign sd_req.wr  = wr;

	// Upper half of the image belongs to console 2
	assign bk.addr = {1'b0, lba[7:0], sd_rsp.buff_addr};
	assign bk.wr1  = ~lba[8] & ~(opts.rom_load_gb2 & opts.dupe_save) &
		sd_rsp.buff_wr & sd_rsp.ack;
	assign bk.wr2  = (lba[8] | opts.dupe_save) & sd_rsp.buff_wr & sd_rsp.ack;

endmodule

`default_nettype wire

// File: bootrom_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb2p_cfg.svh"

module bootrom_tracker (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  gb2p_pkg::ioctl_t     ioctl,
	input  gb2p_pkg::dl_kind_t   kind,
	input  wire                  is_gbc,
	output gb2p_pkg::boot_caps_t caps
);

	logic             custom_cgb;
	logic             custom_dmg;
	logic             boot_q;
	gb2p_pkg::cksum_t cksum;
	logic             cksum_mister;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			custom_cgb <= 1'b0;
			custom_dmg <= 1'b0;
			boot_q     <= 1'b0;
			cksum      <= '0;
		end else begin
			boot_q <= kind.any_boot;
			if (kind.cgb_boot)
				custom_cgb <= 1'b1;
			if (kind.dmg_boot)
				custom_dmg <= 1'b1;

			// Fresh sum for every new CGB boot ROM
			if (kind.cgb_boot && !boot_q)
				cksum <= '0;
			else if (kind.cgb_boot && ioctl.wr)
				cksum <= cksum + gb2p_pkg::cksum_t'(ioctl.dout[15:8]) +
					gb2p_pkg::cksum_t'(ioctl.dout[7:0]);
		end
	end

	assign cksum_mister = (cksum == `GB2P_CKSUM_MISTER);

	////////////////////////////////////////////////////////////
	// Capabilities offered to the menu
	////////////////////////////////////////////////////////////

	assign caps.real_cgb = (cksum == `GB2P_CKSUM_ORIGINAL);

	// GBA mode needs a boot ROM known to support it
	assign caps.gba_avail = !custom_cgb || caps.real_cgb || cksum_mister;

	// SGB boot ROMs never block fast boot
	assign caps.fastboot_avail = !((is_gbc && custom_cgb && !cksum_mister) ||
		(!is_gbc && custom_dmg));

endmodule

`default_nettype wire

// File: download_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb2p_cfg.svh"

module download_decoder (
	input  wire               clk_sys,
	input  wire               reset,
	input  gb2p_pkg::ioctl_t  ioctl,
	output gb2p_pkg::dl_kind_t kind,
	output logic              cart_start,
	output logic              cart_end
);

	logic cart_q;

	// Index match only counts while a download runs
	always_comb begin
		kind.cart     = ioctl.download && (ioctl.index[5:0] == `GB2P_IDX_CART ||
			ioctl.index == `GB2P_IDX_CART_ALT);
		kind.palette  = ioctl.download && (ioctl.index == `GB2P_IDX_PALETTE);
		kind.cgb_boot = ioctl.download && (ioctl.index == `GB2P_IDX_CGB_BOOT);
		kind.dmg_boot = ioctl.download && (ioctl.index == `GB2P_IDX_DMG_BOOT);
		kind.sgb_boot = ioctl.download && (ioctl.index == `GB2P_IDX_SGB_BOOT);
		kind.any_boot = kind.cgb_boot | kind.dmg_boot | kind.sgb_boot;
	end

	// Edge pulses of the cart download, one cycle late
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_q     <= 1'b0;
			cart_start <= 1'b0;
			cart_end   <= 1'b0;
		end else begin
			cart_q     <= kind.cart;
			cart_start <= kind.cart & ~cart_q;
			cart_end   <= ~kind.cart & cart_q;
		end
	end

endmodule

`default_nettype wire

// File: gb2p_cfg.svh
`ifndef GB2P_CFG_SVH
`define GB2P_CFG_SVH

// Boot ROM checksum width and known values
`define GB2P_CKSUM_W 18
`define GB2P_CKSUM_MISTER 18'h2CE10
`define GB2P_CKSUM_ORIGINAL 18'h2F3EA

// Host file indices
`define GB2P_IDX_CART 6'h01
`define GB2P_IDX_CART_ALT 8'h80
`define GB2P_IDX_PALETTE 8'h03
`define GB2P_IDX_CGB_BOOT 8'h04
`define GB2P_IDX_DMG_BOOT 8'h05
`define GB2P_IDX_SGB_BOOT 8'h06

// Save file sector limits
`define GB2P_LAST_SECTOR 9'h1FF
`define GB2P_LAST_SECTOR_DUPE 9'h0FF

// Default palette and audio sample width
`define GB2P_PALETTE_RESET 128'h828214517356305A5F1A3B4900000000
`define GB2P_AUDIO_W 16

`endif

// File: gb2p_glue_top.sv
`timescale 1ns/1ps
`default_nettype none

module gb2p_glue_top (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  gb2p_pkg::ioctl_t      ioctl,
	input  gb2p_pkg::sd_rsp_t     sd_rsp,
	input  wire                   img_mounted,
	input  wire                   img_readonly,
	input  wire [63:0]            img_size,
	input  wire                   osd_open,
	input  wire [1:0]             cram_wr,
	input  wire [1:0]             has_save,
	input  wire                   is_gbc,
	input  gb2p_pkg::save_opts_t  opts,
	input  gb2p_pkg::audio_mode_t audio_mode,
	input  gb2p_pkg::stereo_t     audio1,
	input  gb2p_pkg::stereo_t     audio2,
	output gb2p_pkg::dl_kind_t    dl_kind,
	output gb2p_pkg::boot_caps_t  boot_caps,
	output logic [127:0]          palette,
	output gb2p_pkg::stereo_t     audio_out,
	output gb2p_pkg::sd_req_t     sd_req,
	output gb2p_pkg::bk_wr_t      bk,
	output logic                  core_reset,
	output logic                  led,
	output logic                  bk_busy
);

	logic cart_start;
	logic cart_end;
	logic bk_loading;
	logic sav_pending;

	download_decoder download_decoder_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ioctl     (ioctl),
		.kind      (dl_kind),
		.cart_start(cart_start),
		.cart_end  (cart_end)
	);

	bootrom_tracker bootrom_tracker_i (
		.clk_sys(clk_sys),
		.reset  (reset),
		.ioctl  (ioctl),
		.kind   (dl_kind),
		.is_gbc (is_gbc),
		.caps   (boot_caps)
	);

	palette_store palette_store_i (
		.clk_sys(clk_sys),
		.reset  (reset),
		.ioctl  (ioctl),
		.load   (dl_kind.palette),
		.palette(palette)
	);

	audio_select audio_select_i (
		.clk_sys(clk_sys),
		.reset  (reset),
		.mode   (audio_mode),
		.core1  (audio1),
		.core2  (audio2),
		.mix    (audio_out)
	);

	backup_sequencer backup_sequencer_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.opts        (opts),
		.downloading (dl_kind.cart),
		.cart_start  (cart_start),
		.cart_end    (cart_end),
		.osd_open    (osd_open),
		.img_mounted (img_mounted),
		.img_readonly(img_readonly),
		.img_size    (img_size),
		.cram_wr     (cram_wr),
		.has_save    (has_save),
		.sd_rsp      (sd_rsp),
		.sd_req      (sd_req),
		.bk          (bk),
		.bk_loading  (bk_loading),
		.bk_busy     (bk_busy),
		.sav_pending (sav_pending)
	);

	// Consoles stay in reset while ROMs or save data load
	assign core_reset = reset | dl_kind.cart | dl_kind.any_boot | bk_loading;
	assign led        = ioctl.download | sav_pending;

endmodule

`default_nettype wire

// File: gb2p_pkg.sv
`default_nettype none

`include "gb2p_cfg.svh"

package gb2p_pkg;

	////////////////////////////////////////////////////////////
	// Host side
	////////////////////////////////////////////////////////////

	// One download beat from the host loader
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [24:0] addr;
		logic [15:0] dout;
		logic [7:0]  index;
	} ioctl_t;

	typedef struct packed {
		logic cart;
		logic palette;
		logic cgb_boot;
		logic dmg_boot;
		logic sgb_boot;
		logic any_boot;
	} dl_kind_t;

	typedef logic [`GB2P_CKSUM_W-1:0] cksum_t;

	typedef struct packed {
		logic fastboot_avail;
		logic gba_avail;
		logic real_cgb;
	} boot_caps_t;

	// SD sector request and response
	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	typedef struct packed {
		logic        ack;
		logic [7:0]  buff_addr;
		logic        buff_wr;
		logic [15:0] buff_dout;
	} sd_rsp_t;

	////////////////////////////////////////////////////////////
	// Console side
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic signed [`GB2P_AUDIO_W-1:0] left;
		logic signed [`GB2P_AUDIO_W-1:0] right;
	} stereo_t;

	typedef enum logic [1:0] {
		CORE1 = 2'd0,
		CORE2 = 2'd1,
		MIXED = 2'd2,
		SPLIT = 2'd3
	} audio_mode_t;

	// Menu status bits for backup RAM
	typedef struct packed {
		logic load_req;
		logic save_req;
		logic autosave;
		logic dupe_save;
		logic rom_load_gb2;
	} save_opts_t;

	typedef struct packed {
		logic [16:0] addr;
		logic        wr1;
		logic        wr2;
	} bk_wr_t;

endpackage

`default_nettype wire

// File: list.f
+incdir+.
gb2p_pkg.sv
download_decoder.sv
bootrom_tracker.sv
palette_store.sv
audio_select.sv
backup_sequencer.sv
gb2p_glue_top.sv
tb_gb2p_glue.sv

// File: palette_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb2p_cfg.svh"

module palette_store (
	input  wire              clk_sys,
	input  wire              reset,
	input  gb2p_pkg::ioctl_t ioctl,
	input  wire              load,
	output logic [127:0]     palette
);

	// Four 24 bit colours from the top, low 32 bits unused by video
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette <= `GB2P_PALETTE_RESET;
		end else if (load && ioctl.wr) begin
			// Host words arrive little endian
			palette <= {palette[111:0], ioctl.dout[7:0], ioctl.dout[15:8]};
		end
	end

endmodule

`default_nettype wire

// File: tb_gb2p_checks.svh
`ifndef TB_GB2P_CHECKS_SVH
`define TB_GB2P_CHECKS_SVH

// One step of the 32 bit LCG
function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

////////////////////////////////////////////////////////////
// Typed compares
////////////////////////////////////////////////////////////

task automatic check_stereo(input string name, input gb2p_pkg::stereo_t got,
		input gb2p_pkg::stereo_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		error_count++;
		stop_with_failure();
	end
endtask

task automatic check_caps(input string name, input gb2p_pkg::boot_caps_t got,
		input gb2p_pkg::boot_caps_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		error_count++;
		stop_with_failure();
	end
endtask

task automatic check_kind(input string name, input gb2p_pkg::dl_kind_t got,
		input gb2p_pkg::dl_kind_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		error_count++;
		stop_with_failure();
	end
endtask

task automatic check_palette(input string name, input logic [127:0] got,
		input logic [127:0] exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		error_count++;
		stop_with_failure();
	end
endtask

task automatic check_sd_req(input string name, input gb2p_pkg::sd_req_t got,
		input gb2p_pkg::sd_req_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		error_count++;
		stop_with_failure();
	end
endtask

task automatic check_bk(input string name, input gb2p_pkg::bk_wr_t got,
		input gb2p_pkg::bk_wr_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		error_count++;
		stop_with_failure();
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		error_count++;
		stop_with_failure();
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp) begin
		$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		error_count++;
		stop_with_failure();
	end
endtask

`endif

// File: tb_gb2p_glue.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb2p_cfg.svh"

module tb_gb2p_glue;

	localparam int REQ_TIMEOUT  = 50;
	localparam int IDLE_TIMEOUT = 50;

	logic                  clk_sys;
	logic                  reset;
	gb2p_pkg::ioctl_t      ioctl;
	gb2p_pkg::sd_rsp_t     sd_rsp;
	logic                  img_mounted;
	logic                  img_readonly;
	logic [63:0]           img_size;
	logic                  osd_open;
	logic [1:0]            cram_wr;
	logic [1:0]            has_save;
	logic                  is_gbc;
	gb2p_pkg::save_opts_t  opts;
	gb2p_pkg::audio_mode_t audio_mode;
	gb2p_pkg::stereo_t     audio1;
	gb2p_pkg::stereo_t     audio2;
	gb2p_pkg::dl_kind_t    dl_kind;
	gb2p_pkg::boot_caps_t  boot_caps;
	logic [127:0]          palette;
	gb2p_pkg::stereo_t     audio_out;
	gb2p_pkg::sd_req_t     sd_req;
	gb2p_pkg::bk_wr_t      bk;
	logic                  core_reset;
	logic                  led;
	logic                  bk_busy;

	// Stimulus and expected value tables
	gb2p_pkg::audio_mode_t row_mode [0:15];
	gb2p_pkg::stereo_t     row_core1 [0:15];
	gb2p_pkg::stereo_t     row_core2 [0:15];
	gb2p_pkg::stereo_t     row_mix [0:15];
	logic [15:0]           pal_words [0:4];
	logic [17:0]           boot_sum [0:2];
	gb2p_pkg::boot_caps_t  boot_caps_exp [0:2];

	logic [15:0]           file_buf [0:2047];
	int                    file_len;
	logic [31:0]           lcg_state;
	int                    error_count;
	int                    wr1_beats;
	int                    wr2_beats;

	gb2p_glue_top gb2p_glue_top_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl       (ioctl),
		.sd_rsp      (sd_rsp),
		.img_mounted (img_mounted),
		.img_readonly(img_readonly),
		.img_size    (img_size),
		.osd_open    (osd_open),
		.cram_wr     (cram_wr),
		.has_save    (has_save),
		.is_gbc      (is_gbc),
		.opts        (opts),
		.audio_mode  (audio_mode),
		.audio1      (audio1),
		.audio2      (audio2),
		.dl_kind     (dl_kind),
		.boot_caps   (boot_caps),
		.palette     (palette),
		.audio_out   (audio_out),
		.sd_req      (sd_req),
		.bk          (bk),
		.core_reset  (core_reset),
		.led         (led),
		.bk_busy     (bk_busy)
	);

	`include "tb_gb2p_checks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic stop_with_failure();
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	function logic [15:0] random_half();
		lcg_state = lcg_next(lcg_state);
		return lcg_state[31:16];
	endfunction

	// Each sample halved with its sign kept
	function automatic gb2p_pkg::stereo_t audio_expected(input gb2p_pkg::audio_mode_t mode,
			input gb2p_pkg::stereo_t a, input gb2p_pkg::stereo_t b);
		logic [15:0]       al;
		logic [15:0]       ar;
		logic [15:0]       bl;
		logic [15:0]       br;
		gb2p_pkg::stereo_t res;
		al = {a.left[15], a.left[15:1]};
		ar = {a.right[15], a.right[15:1]};
		bl = {b.left[15], b.left[15:1]};
		br = {b.right[15], b.right[15:1]};
		case (mode)
			gb2p_pkg::CORE1: res = a;
			gb2p_pkg::CORE2: res = b;
			gb2p_pkg::MIXED: begin
				res.left  = al + bl;
				res.right = ar + br;
			end
			default: begin
				res.left  = al + ar;
				res.right = bl + br;
			end
		endcase
		return res;
	endfunction

	task automatic fill_tables();
		int i;
		for (i = 0; i < 16; i++) begin
			row_mode[i]        = gb2p_pkg::audio_mode_t'(i % 4);
			row_core1[i].left  = random_half();
			row_core1[i].right = random_half();
			row_core2[i].left  = random_half();
			row_core2[i].right = random_half();
			row_mix[i]         = audio_expected(row_mode[i], row_core1[i], row_core2[i]);
		end
		pal_words[0] = 16'h3412;
		pal_words[1] = 16'h7856;
		pal_words[2] = 16'hBC9A;
		pal_words[3] = 16'hF0DE;
		pal_words[4] = 16'h0180;
		// Caps with is_gbc set: fastboot, gba, real_cgb
		boot_sum[0]      = 18'h1A2B7;
		boot_caps_exp[0] = 3'b000;
		boot_sum[1]      = `GB2P_CKSUM_MISTER;
		boot_caps_exp[1] = 3'b110;
		boot_sum[2]      = `GB2P_CKSUM_ORIGINAL;
		boot_caps_exp[2] = 3'b011;
	endtask

	// Random words whose byte sum reaches the target exactly
	task automatic build_boot_image(input logic [17:0] target);
		int          remaining;
		int          hi;
		int          lo;
		logic [15:0] word;
		remaining = int'(target);
		file_len  = 0;
		while (remaining >= 510) begin
			word               = random_half();
			file_buf[file_len] = word;
			remaining          = remaining - int'(word[15:8]) - int'(word[7:0]);
			file_len++;
		end
		hi                 = (remaining > 255) ? 255 : remaining;
		lo                 = remaining - hi;
		file_buf[file_len] = {8'(hi), 8'(lo)};
		file_len++;
	endtask

	// Expected kind flags in order cart, palette, cgb, dmg, sgb, any boot
	task automatic download_file(input logic [7:0] index, input int words,
			input gb2p_pkg::dl_kind_t exp_kind);
		int i;
		ioctl.index    = index;
		ioctl.download = 1'b1;
		ioctl.wr       = 1'b0;
		next_cycle();
		check_kind("dl_kind", dl_kind, exp_kind);
		for (i = 0; i < words; i++) begin
			ioctl.wr   = 1'b1;
			ioctl.addr = 25'(i << 1);
			ioctl.dout = file_buf[i];
			next_cycle();
		end
		ioctl.wr       = 1'b0;
		ioctl.download = 1'b0;
		next_cycle();
		check_kind("dl_kind", dl_kind, 6'b000000);
		next_cycle();
	endtask

	////////////////////////////////////////////////////////////
	// Host SD model
	////////////////////////////////////////////////////////////

	task automatic serve_sectors(input int count, input logic load);
		gb2p_pkg::sd_req_t exp_req;
		gb2p_pkg::bk_wr_t  exp_bk;
		int                wait_cycles;
		int                sector;
		int                beat;
		logic [31:0]       lba;
		wr1_beats = 0;
		wr2_beats = 0;
		for (sector = 0; sector < count; sector++) begin
			wait_cycles = 0;
			while (!(sd_req.rd || sd_req.wr)) begin
				if (wait_cycles == REQ_TIMEOUT) begin
					$display("Timeout: no SD request arrived for sector %0d", sector);
					stop_with_failure();
				end
				wait_cycles++;
				next_cycle();
			end
			lba         = sector;
			exp_req.lba = lba;
			exp_req.rd  = load;
			exp_req.wr  = ~load;
			check_sd_req("sd_req", sd_req, exp_req);
			check_flag("bk_busy", bk_busy, 1'b1);
			// Request must hold until the host acks
			repeat (3) begin
				next_cycle();
				check_sd_req("sd_req", sd_req, exp_req);
			end
			for (beat = 0; beat < 256; beat++) begin
				sd_rsp.ack       = 1'b1;
				sd_rsp.buff_addr = beat[7:0];
				sd_rsp.buff_wr   = load;
				sd_rsp.buff_dout = {lba[7:0], beat[7:0]};
				#1;
				exp_bk.addr = {1'b0, lba[7:0], beat[7:0]};
				exp_bk.wr1  = load & ~lba[8] & ~(opts.rom_load_gb2 & opts.dupe_save);
				exp_bk.wr2  = load & (lba[8] | opts.dupe_save);
				check_bk("bk", bk, exp_bk);
				if (load)
					check_flag("core_reset", core_reset, 1'b1);
				if (bk.wr1)
					wr1_beats++;
				if (bk.wr2)
					wr2_beats++;
				next_cycle();
			end
			sd_rsp = '0;
			next_cycle();
		end
		wait_cycles = 0;
		while (bk_busy) begin
			if (wait_cycles == IDLE_TIMEOUT) begin
				$display("Timeout: bk_busy did not fall after the last sector");
				stop_with_failure();
			end
			wait_cycles++;
			next_cycle();
		end
		exp_req.lba = 32'(count - 1);
		exp_req.rd  = 1'b0;
		exp_req.wr  = 1'b0;
		check_sd_req("sd_req idle", sd_req, exp_req);
	endtask

	initial begin
		logic [127:0] exp_pal;
		int           i;

		lcg_state    = 32'ha1f1_afd9;
		error_count  = 0;
		wr1_beats    = 0;
		wr2_beats    = 0;
		file_len     = 0;
		reset        = 1'b1;
		ioctl        = '0;
		sd_rsp       = '0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = '0;
		osd_open     = 1'b0;
		cram_wr      = 2'b00;
		has_save     = 2'b00;
		is_gbc       = 1'b0;
		opts         = '0;
		audio_mode   = gb2p_pkg::CORE1;
		audio1       = '0;
		audio2       = '0;
		fill_tables();
		repeat (5) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		next_cycle();

		////////////////////////////////////////////////////////////
		// Audio and palette
		////////////////////////////////////////////////////////////

		for (i = 0; i < 16; i++) begin
			audio_mode = row_mode[i];
			audio1     = row_core1[i];
			audio2     = row_core2[i];
			next_cycle();
			check_stereo("audio_out", audio_out, row_mix[i]);
		end

		check_palette("palette", palette, `GB2P_PALETTE_RESET);
		exp_pal = `GB2P_PALETTE_RESET;
		for (i = 0; i < 5; i++) begin
			file_buf[i] = pal_words[i];
			exp_pal     = {exp_pal[111:0], pal_words[i][7:0], pal_words[i][15:8]};
		end
		download_file(`GB2P_IDX_PALETTE, 5, 6'b010000);
		check_palette("palette", palette, exp_pal);

		////////////////////////////////////////////////////////////
		// Boot ROM checksum and capabilities
		////////////////////////////////////////////////////////////

		check_caps("boot_caps", boot_caps, 3'b110);
		is_gbc = 1'b1;
		for (i = 0; i < 3; i++) begin
			build_boot_image(boot_sum[i]);
			download_file(`GB2P_IDX_CGB_BOOT, file_len, 6'b001001);
			check_caps("boot_caps", boot_caps, boot_caps_exp[i]);
		end
		is_gbc = 1'b0;
		next_cycle();
		check_caps("boot_caps", boot_caps, 3'b111);
		for (i = 0; i < 8; i++)
			file_buf[i] = random_half();
		download_file(`GB2P_IDX_DMG_BOOT, 8, 6'b000101);
		check_caps("boot_caps", boot_caps, 3'b011);

		////////////////////////////////////////////////////////////
		// Save after a cram write
		////////////////////////////////////////////////////////////

		img_mounted = 1'b1;
		for (i = 0; i < 16; i++)
			file_buf[i] = random_half();
		download_file(8'(`GB2P_IDX_CART), 16, 6'b100000);
		has_save = 2'b01;
		next_cycle();
		check_flag("led", led, 1'b0);
		cram_wr = 2'b01;
		next_cycle();
		cram_wr = 2'b00;
		check_flag("led", led, 1'b1);
		opts.save_req = 1'b1;
		next_cycle();
		opts.save_req = 1'b0;
		serve_sectors(512, 1'b0);
		check_flag("led", led, 1'b0);
		check_count("wr1 beats", wr1_beats, 0);
		check_count("wr2 beats", wr2_beats, 0);

		////////////////////////////////////////////////////////////
		// Auto load, then dupe load
		////////////////////////////////////////////////////////////

		img_size = 64'd131072;
		download_file(`GB2P_IDX_CART_ALT, 16, 6'b100000);
		serve_sectors(512, 1'b1);
		check_count("wr1 beats", wr1_beats, 65536);
		check_count("wr2 beats", wr2_beats, 65536);

		opts.dupe_save = 1'b1;
		opts.load_req  = 1'b1;
		next_cycle();
		opts.load_req = 1'b0;
		serve_sectors(256, 1'b1);
		check_count("wr1 beats", wr1_beats, 65536);
		check_count("wr2 beats", wr2_beats, 65536);

		if (error_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			stop_with_failure();
		end
	end

endmodule

`default_nettype wire
